// ==== vlog.f ====
cache_pkg.sv
sram.sv
cache_ctrl.sv
mem_port.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the cache testbench

TOP := tb_cache

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f *.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

// ==== tb_cache.sv ====
// cache testbench
// random reads and writes checked against a model of memory contents and tags
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    import cache_pkg::*;

    localparam int          NUM_LINES = 8;
    localparam int          NUM_REQS  = 2000;
    localparam int          TIMEOUT   = 1000;
    localparam logic [31:0] SEED      = 32'h27b3_118f;

    logic        CLK;
    logic        rst_n;
    cpu_req_t    req;
    logic        done;
    word_t       rdata;
    logic [15:0] hit_count;
    logic [15:0] miss_count;
    mem_req_t    mem_req;
    logic        mem_ack;
    word_t       mem_rdata;

    // reference model of word memory plus valid and tag per index
    word_t       model_mem [256];
    logic        model_valid [NUM_LINES];
    logic [31:0] model_tag [NUM_LINES];
    logic [15:0] exp_hits;
    logic [15:0] exp_misses;
    integer      seed;

    cache_top #(.NUM_LINES(NUM_LINES)) dut0 (
        .CLK, .rst_n, .req, .done, .rdata, .hit_count, .miss_count,
        .mem_req, .mem_ack, .mem_rdata
    );

    tb_mem_model #(.SEED(SEED)) mem0 (
        .CLK, .rst_n, .mem_req, .mem_ack, .mem_rdata
    );

    always #20 CLK = ~CLK;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // one request from drive to done, then model update and checks
    task automatic run_request(input logic wr, input logic [31:0] addr, input word_t wdata,
                               input strb_t wstrb, input int n);
        int    cycles;
        int    idx;
        int    widx;
        logic  exp_hit;
        word_t got_data;
        word_t exp_data;
        idx      = int'(addr[6:4]);
        widx     = int'(addr[9:2]);
        exp_hit  = model_valid[idx] && (model_tag[idx] == (addr >> 7));
        exp_data = model_mem[widx];
        @(posedge CLK);
        req <= '{rd: !wr, wr: wr, addr: addr, wdata: wdata, wstrb: wstrb};
        // count falling edges until done
        @(negedge CLK);
        cycles = 1;
        while (!done) begin
            if (cycles >= TIMEOUT) begin
                $display("timeout: request %0d at address %h never finished", n, addr);
                $display("TEST FAILED");
                $fatal(1, "no done from the cache");
            end
            @(negedge CLK);
            cycles++;
        end
        // rdata only valid while the request is still held
        got_data = rdata;
        @(posedge CLK);
        req <= '0;
        if (wr) begin
            // write-through under strobes without allocation
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    model_mem[widx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (exp_hit) begin
            exp_hits++;
        end else begin
            exp_misses++;
            model_valid[idx] = 1'b1;
            model_tag[idx]   = addr >> 7;
        end
        // counters settle one edge after a hit
        @(negedge CLK);
        if (!wr) begin
            check("rdata", got_data, exp_data);
            if (exp_hit) begin
                check("hit_latency", cycles, 2);
            end
        end else begin
            check("mem0.words", mem0.words[widx], model_mem[widx]);
        end
        check("hit_count", {16'h0, hit_count}, {16'h0, exp_hits});
        check("miss_count", {16'h0, miss_count}, {16'h0, exp_misses});
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] last_addr;
        logic        wr;
        logic        readback;
        word_t       wdata;
        strb_t       wstrb;
        CLK   = 1'b0;
        rst_n = 1'b0;
        req   = '0;
        seed  = SEED;
        // same fill as mem0
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = $random(seed);
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        exp_hits   = '0;
        exp_misses = '0;
        last_addr  = '0;
        readback   = 1'b0;
        repeat (2) @(posedge CLK);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_REQS; n++) begin
            wdata = $random(seed);
            wstrb = strb_t'($random(seed));
            if (readback) begin
                // read straight back the address just written
                addr = last_addr;
                wr   = 1'b0;
            end else begin
                // half the time stay on the last line, else anywhere in 1 KB
                if ((n > 0) && (($random(seed) & 1) != 0)) begin
                    addr = {last_addr[31:4], 4'b0} | ($random(seed) & 32'h0000_000c);
                end else begin
                    addr = $random(seed) & 32'h0000_03fc;
                end
                wr = (($random(seed) & 3) == 0);
            end
            run_request(wr, addr, wdata, wstrb, n);
            readback  = wr;
            last_addr = addr;
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// testbench memory
// 256-word store, answers each read or write after a random 0 to 3 cycle delay
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'h27b3_118f
) (
    input  wire logic                   CLK,
    input  wire logic                   rst_n,
    input  wire cache_pkg::mem_req_t    mem_req,
    output logic                        mem_ack,
    output cache_pkg::word_t            mem_rdata
);

    import cache_pkg::*;

    // contents that the testbench top reads for store checks
    word_t      words [256];
    integer     seed;
    logic       busy;
    logic [1:0] wait_cnt;
    logic [7:0] widx;

    // word index inside the 1 KB window
    assign widx = mem_req.addr[9:2];

    // same random sequence the testbench uses for its own copy
    initial begin
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
        seed = SEED;
        for (int i = 0; i < 256; i++) begin
            words[i] = $random(seed);
        end
    end

    always @(posedge CLK) begin
        logic [1:0] wait_now;
        // ack is a single-cycle pulse
        mem_ack <= 1'b0;
        if (!rst_n) begin
            busy      <= 1'b0;
            wait_cnt  <= '0;
            mem_rdata <= '0;
        end else if (!mem_ack && (mem_req.rd || mem_req.wr)) begin
            // new request draws its delay, a waiting one counts down
            if (busy) begin
                wait_now = wait_cnt;
            end else begin
                wait_now = 2'($random(seed));
            end
            if (wait_now == 2'd0) begin
                mem_ack   <= 1'b1;
                busy      <= 1'b0;
                mem_rdata <= words[widx];
                if (mem_req.wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.wstrb[b]) begin
                            words[widx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                        end
                    end
                end
            end else begin
                busy     <= 1'b1;
                wait_cnt <= wait_now - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
// cache top level
// controller, tag and data arrays and the external memory port
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int NUM_LINES = 64
) (
    input  wire logic                   CLK,
    input  wire logic                   rst_n,
    input  wire cache_pkg::cpu_req_t    req,
    output logic                        done,
    output cache_pkg::word_t            rdata,
    output logic [15:0]                 hit_count,
    output logic [15:0]                 miss_count,
    output cache_pkg::mem_req_t         mem_req,
    input  wire logic                   mem_ack,
    input  wire cache_pkg::word_t       mem_rdata
);

    import cache_pkg::*;

    localparam int IDX_W       = $clog2(NUM_LINES);
    localparam int TAG_ENTRY_W = tag_entry_bits(NUM_LINES);

    // tag array
    logic [IDX_W-1:0]       tag_sel;
    logic                   tag_wen;
    logic [TAG_ENTRY_W-1:0] tag_wval;
    logic [TAG_ENTRY_W-1:0] tag_wmask;
    logic [TAG_ENTRY_W-1:0] tag_rval;

    // data array
    logic [IDX_W-1:0] data_sel;
    logic             data_wen;
    line_t            data_wval;
    line_t            data_wmask;
    line_t            data_rval;

    // controller to memory port
    logic        fill_start;
    logic [31:0] fill_addr;
    logic        fill_done;
    line_t       fill_line;
    logic        store_start;
    mem_req_t    store_req;
    logic        store_done;

    cache_ctrl #(.NUM_LINES(NUM_LINES)) ctrl0 (
        .CLK, .rst_n, .req, .done, .rdata, .hit_count, .miss_count,
        .tag_sel, .tag_wen, .tag_wval, .tag_wmask, .tag_rval,
        .data_sel, .data_wen, .data_wval, .data_wmask, .data_rval,
        .fill_start, .fill_addr, .fill_done, .fill_line,
        .store_start, .store_req, .store_done
    );

    sram #(.entry_t(logic [TAG_ENTRY_W-1:0]), .DEPTH(NUM_LINES)) tag0 (
        .CLK, .rst_n, .wen(tag_wen), .sel(tag_sel),
        .wval(tag_wval), .wmask(tag_wmask), .rval(tag_rval)
    );

    sram #(.entry_t(line_t), .DEPTH(NUM_LINES)) data0 (
        .CLK, .rst_n, .wen(data_wen), .sel(data_sel),
        .wval(data_wval), .wmask(data_wmask), .rval(data_rval)
    );

    mem_port mport0 (
        .CLK, .rst_n,
        .fill_start, .fill_addr, .fill_done, .fill_line,
        .store_start, .store_req, .store_done,
        .mem_req, .mem_ack, .mem_rdata
    );

endmodule

`default_nettype wire

// ==== mem_port.sv ====
// external memory sequencer
// four-beat line refill and single-word store forwarding, each beat held until ack
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  wire logic                   CLK,
    input  wire logic                   rst_n,
    input  wire logic                   fill_start,
    input  wire logic [31:0]            fill_addr,
    output logic                        fill_done,
    output cache_pkg::line_t            fill_line,
    input  wire logic                   store_start,
    input  wire cache_pkg::mem_req_t    store_req,
    output logic                        store_done,
    output cache_pkg::mem_req_t         mem_req,
    input  wire logic                   mem_ack,
    input  wire cache_pkg::word_t       mem_rdata
);

    import cache_pkg::*;

    localparam int BEAT_W = $clog2(WORDS_PER_LINE);

    // control
    logic              rd_q;
    logic              wr_q;
    logic [BEAT_W-1:0] beat;

    // payload
    logic [ADDR_W-1:0] addr_q;
    word_t             wdata_q;
    strb_t             wstrb_q;
    line_t             line_q;

    logic last_beat;

    assign last_beat = (beat == BEAT_W'(WORDS_PER_LINE - 1));

    assign mem_req.rd    = rd_q;
    assign mem_req.wr    = wr_q;
    assign mem_req.addr  = addr_q;
    assign mem_req.wdata = wdata_q;
    assign mem_req.wstrb = wstrb_q;

    // done pulses in the ack cycle of the last beat
    assign fill_done  = rd_q && mem_ack && last_beat;
    assign store_done = wr_q && mem_ack;

    // last word comes straight from the bus
    always_comb begin
        fill_line       = line_q;
        fill_line[beat] = mem_rdata;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
            beat <= '0;
        end else if (fill_start) begin
            rd_q <= 1'b1;
            beat <= '0;
        end else if (store_start) begin
            wr_q <= store_req.wr;
        end else if (mem_ack) begin
            if (rd_q) begin
                beat <= beat + 1'b1;
                if (last_beat) begin
                    rd_q <= 1'b0;
                end
            end
            if (wr_q) begin
                wr_q <= 1'b0;
            end
        end
    end

    // address steps a word per read beat
    always_ff @(posedge CLK) begin
        if (fill_start) begin
            addr_q  <= fill_addr;
            wdata_q <= '0;
            wstrb_q <= '0;
        end else if (store_start) begin
            addr_q  <= store_req.addr;
            wdata_q <= store_req.wdata;
            wstrb_q <= store_req.wstrb;
        end else if (rd_q && mem_ack) begin
            line_q[beat] <= mem_rdata;
            addr_q       <= addr_q + 32'd4;
        end
    end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
// direct-mapped write-through cache controller
// tag compare, refill and store sequencing, array updates and hit/miss counters
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int NUM_LINES = 64
) (
    input  wire logic                                               CLK,
    input  wire logic                                               rst_n,
    input  wire cache_pkg::cpu_req_t                                req,
    output logic                                                    done,
    output cache_pkg::word_t                                        rdata,
    output logic [15:0]                                             hit_count,
    output logic [15:0]                                             miss_count,
    output logic [$clog2(NUM_LINES)-1:0]                            tag_sel,
    output logic                                                    tag_wen,
    output logic [cache_pkg::tag_entry_bits(NUM_LINES)-1:0]         tag_wval,
    output logic [cache_pkg::tag_entry_bits(NUM_LINES)-1:0]         tag_wmask,
    input  wire logic [cache_pkg::tag_entry_bits(NUM_LINES)-1:0]    tag_rval,
    output logic [$clog2(NUM_LINES)-1:0]                            data_sel,
    output logic                                                    data_wen,
    output cache_pkg::line_t                                        data_wval,
    output cache_pkg::line_t                                        data_wmask,
    input  wire cache_pkg::line_t                                   data_rval,
    output logic                                                    fill_start,
    output logic [31:0]                                             fill_addr,
    input  wire logic                                               fill_done,
    input  wire cache_pkg::line_t                                   fill_line,
    output logic                                                    store_start,
    output cache_pkg::mem_req_t                                     store_req,
    input  wire logic                                               store_done
);

    import cache_pkg::*;

    localparam int IDX_W  = $clog2(NUM_LINES);
    localparam int WSEL_W = $clog2(WORDS_PER_LINE);
    localparam int TAG_W  = tag_entry_bits(NUM_LINES) - 1;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        S_CLEAR,
        S_IDLE,
        S_LOOKUP,
        S_REFILL,
        S_STORE,
        S_RESPOND
    } state_t;

    state_t state;
    state_t state_nxt;

    logic [IDX_W-1:0]  clr_idx;
    // high in the cycle right after done, blocks re-accepting a held request
    logic              done_q;

    // request address fields
    logic [IDX_W-1:0]  req_idx;
    logic [TAG_W-1:0]  req_tag;
    logic [WSEL_W-1:0] req_wsel;

    tag_entry_t tag_rd;
    tag_entry_t tag_new;
    logic       hit;
    logic       rd_hit_now;

    assign req_idx  = req.addr[LINE_OFFSET_W +: IDX_W];
    assign req_tag  = req.addr[ADDR_W-1 -: TAG_W];
    assign req_wsel = req.addr[BYTE_OFFSET_W +: WSEL_W];

    // compare against the indexed entry
    assign tag_rd = tag_entry_t'(tag_rval);
    assign hit    = tag_rd.valid && (tag_rd.tag == req_tag);

    assign rd_hit_now = (state == S_LOOKUP) && !req.wr && hit;

    // clear sweep walks the tag array and both otherwise follow the request
    assign tag_sel  = (state == S_CLEAR) ? clr_idx : req_idx;
    assign data_sel = req_idx;

    always_comb begin
        state_nxt = state;
        case (state)
            S_CLEAR: begin
                if (clr_idx == IDX_W'(NUM_LINES - 1)) begin
                    state_nxt = S_IDLE;
                end
            end
            S_IDLE: begin
                if ((req.rd || req.wr) && !done_q) begin
                    state_nxt = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (req.wr) begin
                    state_nxt = S_STORE;
                end else if (hit) begin
                    state_nxt = S_IDLE;
                end else begin
                    state_nxt = S_REFILL;
                end
            end
            S_REFILL: begin
                if (fill_done) begin
                    state_nxt = S_RESPOND;
                end
            end
            S_STORE: begin
                if (store_done) begin
                    state_nxt = S_RESPOND;
                end
            end
            S_RESPOND: state_nxt = S_IDLE;
            default:   state_nxt = S_CLEAR;
        endcase
    end

    // read hits finish in lookup, everything else in respond
    assign done  = rd_hit_now || (state == S_RESPOND);
    assign rdata = data_rval[req_wsel];

    // miss goes out as a line fill from the line base
    assign fill_start = (state == S_LOOKUP) && !req.wr && !hit;
    assign fill_addr  = {req.addr[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};

    // every write is forwarded to memory whether it hits or not
    assign store_start     = (state == S_LOOKUP) && req.wr;
    assign store_req.rd    = 1'b0;
    assign store_req.wr    = 1'b1;
    assign store_req.addr  = {req.addr[ADDR_W-1:BYTE_OFFSET_W], {BYTE_OFFSET_W{1'b0}}};
    assign store_req.wdata = req.wdata;
    assign store_req.wstrb = req.wstrb;

    // clear zeroes each tag entry and a refill installs a valid one
    assign tag_wen       = (state == S_CLEAR) || ((state == S_REFILL) && fill_done);
    assign tag_new.valid = (state != S_CLEAR);
    assign tag_new.tag   = (state == S_CLEAR) ? '0 : req_tag;
    assign tag_wval      = tag_new;
    assign tag_wmask     = '0;

    // tag array is untouched by writes, so hit still holds in respond
    assign data_wen = ((state == S_REFILL) && fill_done)
                    || ((state == S_RESPOND) && req.wr && hit);

    always_comb begin
        // refill installs the whole line
        data_wval  = fill_line;
        data_wmask = '0;
        if (state == S_RESPOND) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                data_wval[w] = req.wdata;
            end
            // keep everything except the strobed bytes of the selected word
            data_wmask = '1;
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (req.wstrb[b]) begin
                    data_wmask[req_wsel][8*b +: 8] = 8'h00;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state      <= S_CLEAR;
            clr_idx    <= '0;
            done_q     <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            state  <= state_nxt;
            done_q <= done;
            if (state == S_CLEAR) begin
                clr_idx <= clr_idx + 1'b1;
            end
            // only reads are counted
            if ((state == S_LOOKUP) && !req.wr) begin
                if (hit) begin
                    hit_count <= hit_count + 16'd1;
                end else begin
                    miss_count <= miss_count + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sram.sv ====
// single-port storage array
// combinational read, clocked write where a mask bit of one keeps the old bit
`timescale 1ns/1ps
`default_nettype none

module sram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 64
) (
    input  wire logic                        CLK,
    input  wire logic                        rst_n,
    input  wire logic                        wen,
    input  wire logic [$clog2(DEPTH)-1:0]    sel,
    input  wire entry_t                      wval,
    input  wire logic [$bits(entry_t)-1:0]   wmask,
    output entry_t                           rval
);

    localparam int W = $bits(entry_t);

    // one entry per index
    entry_t mem [DEPTH];

    // flat views for the bitwise merge
    logic [W-1:0] old_bits;
    logic [W-1:0] new_bits;
    logic [W-1:0] merged;

    // read port always on
    assign rval = mem[sel];

    assign old_bits = mem[sel];
    assign new_bits = wval;

    // mask one keeps the stored bit
    assign merged = (new_bits & ~wmask) | (old_bits & wmask);

    // writes held off while in reset
    always_ff @(posedge CLK) begin
        if (wen && rst_n) begin
            mem[sel] <= entry_t'(merged);
        end
    end

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
// cache package
// word, line and request types shared by the cache controller and memory port
`default_nettype none

package cache_pkg;

    // fixed geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int WORDS_PER_LINE = 4;

    // byte-in-word and byte-in-line offset widths
    localparam int BYTE_OFFSET_W = $clog2(BYTES_PER_WORD);
    localparam int LINE_OFFSET_W = BYTE_OFFSET_W + $clog2(WORDS_PER_LINE);

    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [BYTES_PER_WORD-1:0] strb_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // processor request with rd and wr never both high
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        strb_t             wstrb;
    } cpu_req_t;

    // memory request with a word aligned addr
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        strb_t             wstrb;
    } mem_req_t;

    // valid bit plus the tag left above index and offset
    function automatic int tag_entry_bits(input int num_lines);
        return 1 + ADDR_W - LINE_OFFSET_W - $clog2(num_lines);
    endfunction

endpackage

`default_nettype wire
